//--- Makefile
VERILATOR  ?= verilator
TOP        := link_tb
FILELIST   := build.f
FLAGS      := --binary --timing --assert
LINT_FLAGS := --lint-only --timing
OBJ_DIR    := obj_dir
PASS_MSG   := No errors

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only when the pass line shows up in the output
run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
rtl/link_pkg.sv
rtl/sysref_lmfc.sv
rtl/tx_framer.sv
rtl/lane_buffer.sv
rtl/rx_deframer.sv
rtl/link_loopback.sv
sim/clk_gen.sv
sim/link_props.sv
sim/link_tb.sv

//--- rtl/lane_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module lane_buffer import link_pkg::*; #(
  parameter int BUF_DEPTH = 8
) (
  input  wire                 device_clk,
  input  wire                 rst,
  input  wire                 lane_push,
  input  wire  [sample_w-1:0] lane_data,
  input  lane_char_t          lane_char,
  output logic                head_valid,
  output logic [sample_w-1:0] head_data,
  output lane_char_t          head_char,
  input  wire                 pop,
  output logic                credit_return
);

  localparam int PTR_W = (BUF_DEPTH > 1) ? $clog2(BUF_DEPTH) : 1;
  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  // Storage for the lane words and their control marking
  logic [sample_w-1:0] mem_data [BUF_DEPTH];
  lane_char_t          mem_char [BUF_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] occupancy;
  logic             do_pop;

  // A pop against an empty buffer is ignored and returns nothing
  assign do_pop = pop && head_valid;

  // ********************
  // Head of the queue
  // ********************

  // The oldest word is shown without a register stage
  assign head_valid = (occupancy != '0);
  assign head_data  = mem_data[rd_ptr];
  assign head_char  = mem_char[rd_ptr];

  always_ff @(posedge device_clk) begin
    if (rst) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      occupancy     <= '0;
      credit_return <= 1'b0;
    end else begin
      // The depth need not be a power of two, so pointers wrap explicitly
      if (lane_push) begin
        wr_ptr <= (wr_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      occupancy     <= occupancy + CNT_W'(lane_push) - CNT_W'(do_pop);
      // One credit goes back to the framer for each word that leaves
      credit_return <= do_pop;
    end
  end

  // The framer never pushes without a credit, so a push always has room
  always_ff @(posedge device_clk) begin
    if (lane_push) begin
      mem_data[wr_ptr] <= lane_data;
      mem_char[wr_ptr] <= lane_char;
    end
  end

endmodule

`default_nettype wire

//--- rtl/link_loopback.sv
`timescale 1ns/1ps
`default_nettype none

module link_loopback import link_pkg::*; #(
  parameter int NUM_CHANNELS    = num_channels_dflt,
  parameter int FRAMES_PER_MF   = frames_per_mf_dflt,
  parameter int BUF_DEPTH       = buf_depth_dflt,
  parameter int CGS_MULTIFRAMES = cgs_multiframes_dflt
) (
  input  wire                              device_clk,
  input  wire                              rst,
  input  wire                              sysref,
  input  wire                              link_enable,
  input  wire                              tx_valid,
  input  wire  [NUM_CHANNELS*sample_w-1:0] tx_data,
  output logic                             tx_ready,
  output logic                             rx_valid,
  output logic [NUM_CHANNELS*sample_w-1:0] rx_data,
  input  wire                              rx_ready,
  output logic                             link_up
);

  // ********************
  // Lane between the ends
  // ********************

  logic                lmfc_edge;
  logic                lane_push;
  logic [sample_w-1:0] lane_data;
  lane_char_t          lane_char;
  logic                credit_return;
  logic                head_valid;
  logic [sample_w-1:0] head_data;
  lane_char_t          head_char;
  logic                pop;

  // Multiframe clock that paces the start of alignment
  sysref_lmfc #(
    .NUM_CHANNELS  (NUM_CHANNELS),
    .FRAMES_PER_MF (FRAMES_PER_MF)
  ) i_sysref_lmfc (
    .device_clk (device_clk),
    .rst        (rst),
    .sysref     (sysref),
    .lmfc_edge  (lmfc_edge)
  );

  tx_framer #(
    .NUM_CHANNELS    (NUM_CHANNELS),
    .FRAMES_PER_MF   (FRAMES_PER_MF),
    .BUF_DEPTH       (BUF_DEPTH),
    .CGS_MULTIFRAMES (CGS_MULTIFRAMES)
  ) i_tx_framer (
    .device_clk    (device_clk),
    .rst           (rst),
    .link_enable   (link_enable),
    .lmfc_edge     (lmfc_edge),
    .tx_valid      (tx_valid),
    .tx_data       (tx_data),
    .tx_ready      (tx_ready),
    .lane_push     (lane_push),
    .lane_data     (lane_data),
    .lane_char     (lane_char),
    .credit_return (credit_return)
  );

  // The buffer depth is also the framer's starting credit
  lane_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) i_lane_buffer (
    .device_clk    (device_clk),
    .rst           (rst),
    .lane_push     (lane_push),
    .lane_data     (lane_data),
    .lane_char     (lane_char),
    .head_valid    (head_valid),
    .head_data     (head_data),
    .head_char     (head_char),
    .pop           (pop),
    .credit_return (credit_return)
  );

  rx_deframer #(
    .NUM_CHANNELS  (NUM_CHANNELS),
    .FRAMES_PER_MF (FRAMES_PER_MF)
  ) i_rx_deframer (
    .device_clk (device_clk),
    .rst        (rst),
    .head_valid (head_valid),
    .head_data  (head_data),
    .head_char  (head_char),
    .pop        (pop),
    .rx_valid   (rx_valid),
    .rx_data    (rx_data),
    .rx_ready   (rx_ready),
    .link_up    (link_up)
  );

endmodule

`default_nettype wire

//--- rtl/link_pkg.sv
`default_nettype none

// ********************
// Shared definitions for the loopback link
// ********************

package link_pkg;

  // Width of one converter sample, and also the width of a lane word
  localparam int sample_w = 16;

  // Default link geometry, picked up by the top level and by the testbench
  localparam int num_channels_dflt    = 4;
  localparam int frames_per_mf_dflt   = 4;
  localparam int buf_depth_dflt       = 8;
  localparam int cgs_multiframes_dflt = 2;

  // Control marking carried next to every lane word
  // A K character replaces the 8b/10b control symbols of a real link
  typedef enum logic [1:0] {
    DATA_WORD    = 2'd0,
    K_CGS        = 2'd1,
    K_ILAS_START = 2'd2,
    K_ILAS_END   = 2'd3
  } lane_char_t;

  // Transmit side bring-up sequence
  typedef enum logic [1:0] {
    TX_IDLE = 2'd0,
    TX_CGS  = 2'd1,
    TX_ILAS = 2'd2,
    TX_DATA = 2'd3
  } tx_state_t;

  // Receive side lock sequence
  typedef enum logic [1:0] {
    RX_WAIT_CGS  = 2'd0,
    RX_WAIT_ILAS = 2'd1,
    RX_ILAS      = 2'd2,
    RX_DATA      = 2'd3
  } rx_state_t;

endpackage

`default_nettype wire

//--- rtl/rx_deframer.sv
`timescale 1ns/1ps
`default_nettype none

module rx_deframer import link_pkg::*; #(
  parameter int NUM_CHANNELS  = 4,
  parameter int FRAMES_PER_MF = 4
) (
  input  wire                              device_clk,
  input  wire                              rst,
  input  wire                              head_valid,
  input  wire  [sample_w-1:0]              head_data,
  input  lane_char_t                       head_char,
  output logic                             pop,
  output logic                             rx_valid,
  output logic [NUM_CHANNELS*sample_w-1:0] rx_data,
  input  wire                              rx_ready,
  output logic                             link_up
);

  localparam int MF_WORDS = NUM_CHANNELS * FRAMES_PER_MF;
  localparam int MF_W     = (MF_WORDS > 1) ? $clog2(MF_WORDS) : 1;
  localparam int CH_W     = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

  rx_state_t                        state;
  logic [CH_W-1:0]                  ch_idx;
  logic [MF_W-1:0]                  ilas_cnt;
  logic [MF_W-1:0]                  idle_cnt;
  logic [NUM_CHANNELS*sample_w-1:0] asm_buf;
  logic [NUM_CHANNELS*sample_w-1:0] frame_next;
  logic                             frame_last;
  logic                             idle_timeout;

  // Words are taken whenever the output register can still accept a frame
  // A held rx_valid stops the lane, the buffer fills and the framer stalls
  assign pop = head_valid && (!rx_valid || rx_ready);

  assign frame_last = (ch_idx == CH_W'(NUM_CHANNELS - 1));

  // The transmitter sends nothing once disabled, so a full multiframe of
  // empty lane while linked counts as loss of link
  assign idle_timeout = (state == RX_DATA) && !head_valid &&
                        (idle_cnt == MF_W'(MF_WORDS - 1));

  // The frame as it stands once the head word is placed in its slot
  always_comb begin
    frame_next = asm_buf;
    frame_next[ch_idx*sample_w +: sample_w] = head_data;
  end

  // ********************
  // Lock state machine
  // ********************

  always_ff @(posedge device_clk) begin
    if (rst) begin
      state    <= RX_WAIT_CGS;
      link_up  <= 1'b0;
      rx_valid <= 1'b0;
      ch_idx   <= '0;
      ilas_cnt <= '0;
      idle_cnt <= '0;
    end else begin
      if (rx_valid && rx_ready) rx_valid <= 1'b0;
      if ((state == RX_DATA) && !head_valid) begin
        idle_cnt <= idle_cnt + 1'b1;
      end else begin
        idle_cnt <= '0;
      end
      if (pop) begin
        case (state)
          RX_WAIT_CGS: begin
            if (head_char == K_CGS) state <= RX_WAIT_ILAS;
          end
          RX_WAIT_ILAS: begin
            // Filler is skipped, anything but the alignment start loses sync
            if (head_char == K_ILAS_START) begin
              state    <= RX_ILAS;
              ilas_cnt <= '0;
            end else if (head_char != K_CGS) begin
              state <= RX_WAIT_CGS;
            end
          end
          RX_ILAS: begin
            // Exactly one multiframe less its two markers must pass
            if ((head_char == DATA_WORD) && (ilas_cnt != MF_W'(MF_WORDS - 2))) begin
              ilas_cnt <= ilas_cnt + 1'b1;
            end else if ((head_char == K_ILAS_END) &&
                         (ilas_cnt == MF_W'(MF_WORDS - 2))) begin
              state   <= RX_DATA;
              link_up <= 1'b1;
              ch_idx  <= '0;
            end else begin
              state <= RX_WAIT_CGS;
            end
          end
          RX_DATA: begin
            if (head_char == DATA_WORD) begin
              ch_idx <= frame_last ? '0 : ch_idx + 1'b1;
              if (frame_last) rx_valid <= 1'b1;
            end else if (head_char == K_CGS) begin
              // The far end is resyncing, drop the partial frame and follow it
              state   <= RX_WAIT_ILAS;
              link_up <= 1'b0;
              ch_idx  <= '0;
            end else begin
              state   <= RX_WAIT_CGS;
              link_up <= 1'b0;
              ch_idx  <= '0;
            end
          end
          default: state <= RX_WAIT_CGS;
        endcase
      end else if (idle_timeout) begin
        state   <= RX_WAIT_CGS;
        link_up <= 1'b0;
        ch_idx  <= '0;
      end
    end
  end

  // Samples collect in the assembly buffer, channel 0 in the low bits
  // rx_data only changes on a completed frame, which keeps it stable while held
  always_ff @(posedge device_clk) begin
    if (pop && (state == RX_DATA) && (head_char == DATA_WORD)) begin
      asm_buf <= frame_next;
      if (frame_last) rx_data <= frame_next;
    end
  end

endmodule

`default_nettype wire

//--- rtl/sysref_lmfc.sv
`timescale 1ns/1ps
`default_nettype none

module sysref_lmfc #(
  parameter int NUM_CHANNELS  = 4,
  parameter int FRAMES_PER_MF = 4
) (
  input  wire  device_clk,
  input  wire  rst,
  input  wire  sysref,
  output logic lmfc_edge
);

  // One multiframe is one lane word per sample of every frame in it
  localparam int MF_WORDS = NUM_CHANNELS * FRAMES_PER_MF;
  localparam int CNT_W    = (MF_WORDS > 1) ? $clog2(MF_WORDS) : 1;

  logic             sysref_d;
  logic             sysref_rise;
  logic [CNT_W-1:0] lmfc_cnt;
  logic             lmfc_wrap;

  // ********************
  // SYSREF edge detect
  // ********************

  // Only the rising edge re-phases the counter, so a level held high
  // (or an inverted pulse train) moves the phase once per edge
  assign sysref_rise = sysref & ~sysref_d;

  // Last count of the multiframe
  assign lmfc_wrap = (lmfc_cnt == CNT_W'(MF_WORDS - 1));

  always_ff @(posedge device_clk) begin
    if (rst) begin
      sysref_d  <= 1'b0;
      lmfc_cnt  <= '0;
      lmfc_edge <= 1'b0;
    end else begin
      sysref_d <= sysref;
      if (sysref_rise) begin
        // A new reference restarts the multiframe at once
        // The boundary pulse lands in the cycle that holds count zero
        lmfc_cnt  <= '0;
        lmfc_edge <= 1'b1;
      end else begin
        lmfc_cnt  <= lmfc_wrap ? '0 : lmfc_cnt + 1'b1;
        lmfc_edge <= lmfc_wrap;
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/tx_framer.sv
`timescale 1ns/1ps
`default_nettype none

module tx_framer import link_pkg::*; #(
  parameter int NUM_CHANNELS    = 4,
  parameter int FRAMES_PER_MF   = 4,
  parameter int BUF_DEPTH       = 8,
  parameter int CGS_MULTIFRAMES = 2
) (
  input  wire                                device_clk,
  input  wire                                rst,
  input  wire                                link_enable,
  input  wire                                lmfc_edge,
  input  wire                                tx_valid,
  input  wire  [NUM_CHANNELS*sample_w-1:0]   tx_data,
  output logic                               tx_ready,
  output logic                               lane_push,
  output logic [sample_w-1:0]                lane_data,
  output lane_char_t                         lane_char,
  input  wire                                credit_return
);

  localparam int MF_WORDS = NUM_CHANNELS * FRAMES_PER_MF;
  localparam int MF_W     = (MF_WORDS > 1) ? $clog2(MF_WORDS) : 1;
  localparam int CRED_W   = $clog2(BUF_DEPTH + 1);
  localparam int CGS_W    = $clog2(CGS_MULTIFRAMES + 1);

  tx_state_t                       state;
  tx_state_t                       state_nxt;
  logic [CRED_W-1:0]               credits;
  logic [CGS_W-1:0]                cgs_cnt;
  logic [MF_W-1:0]                 word_idx;
  logic                            busy;
  logic [NUM_CHANNELS*sample_w-1:0] frame_q;
  logic                            have_credit;
  logic                            cgs_done;
  logic                            ilas_last;
  logic                            frame_last;
  logic                            tx_accept;
  logic                            push_now;
  logic [sample_w-1:0]             push_data;
  lane_char_t                      push_char;

  assign have_credit = (credits != '0);
  assign cgs_done    = (cgs_cnt == CGS_W'(CGS_MULTIFRAMES));
  assign ilas_last   = (word_idx == MF_W'(MF_WORDS - 1));
  assign frame_last  = (word_idx == MF_W'(NUM_CHANNELS - 1));

  // A frame is only taken when every one of its samples already has a
  // credit, so a started frame never stalls half way on the lane
  assign tx_ready  = (state == TX_DATA) && link_enable && !busy &&
                     (credits >= CRED_W'(NUM_CHANNELS));
  assign tx_accept = tx_valid && tx_ready;

  // ********************
  // Word selection
  // ********************

  always_comb begin
    state_nxt = state;
    push_now  = 1'b0;
    push_data = '0;
    push_char = K_CGS;
    case (state)
      TX_IDLE: begin
        if (link_enable) state_nxt = TX_CGS;
      end
      TX_CGS: begin
        // Sync filler goes out whenever the buffer has room for it
        push_now = have_credit;
        if (lmfc_edge && cgs_done) state_nxt = TX_ILAS;
      end
      TX_ILAS: begin
        // Alignment payload words carry their own position in the multiframe
        push_now  = have_credit;
        push_data = sample_w'(word_idx);
        if (word_idx == '0) begin
          push_char = K_ILAS_START;
        end else if (ilas_last) begin
          push_char = K_ILAS_END;
        end else begin
          push_char = DATA_WORD;
        end
        if (have_credit && ilas_last) state_nxt = TX_DATA;
      end
      TX_DATA: begin
        push_char = DATA_WORD;
        if (tx_accept) begin
          // Channel 0 leaves straight from the input in the accept cycle
          push_now  = 1'b1;
          push_data = tx_data[0 +: sample_w];
        end else if (busy && have_credit) begin
          push_now  = 1'b1;
          push_data = frame_q[word_idx*sample_w +: sample_w];
        end
      end
      default: state_nxt = TX_IDLE;
    endcase
    // Losing the enable abandons whatever is under way
    if (!link_enable) begin
      state_nxt = TX_IDLE;
      push_now  = 1'b0;
    end
  end

  // ********************
  // Control registers
  // ********************

  always_ff @(posedge device_clk) begin
    if (rst) begin
      state     <= TX_IDLE;
      credits   <= CRED_W'(BUF_DEPTH);
      cgs_cnt   <= '0;
      word_idx  <= '0;
      busy      <= 1'b0;
      lane_push <= 1'b0;
    end else begin
      state     <= state_nxt;
      lane_push <= push_now;
      // Credits are spent at the decision and come back one per popped word
      credits   <= credits - CRED_W'(push_now) + CRED_W'(credit_return);
      if (!link_enable) begin
        cgs_cnt  <= '0;
        word_idx <= '0;
        busy     <= 1'b0;
      end else begin
        case (state)
          TX_CGS: begin
            if (lmfc_edge && !cgs_done) cgs_cnt <= cgs_cnt + 1'b1;
          end
          TX_ILAS: begin
            if (have_credit) word_idx <= ilas_last ? '0 : word_idx + 1'b1;
          end
          TX_DATA: begin
            if (tx_accept) begin
              word_idx <= MF_W'(1);
              busy     <= (NUM_CHANNELS > 1);
            end else if (busy && have_credit) begin
              word_idx <= frame_last ? '0 : word_idx + 1'b1;
              busy     <= !frame_last;
            end
          end
          default: begin
            cgs_cnt  <= '0;
            word_idx <= '0;
          end
        endcase
      end
    end
  end

  // Lane payload and the held frame only move with a push or an accept
  always_ff @(posedge device_clk) begin
    if (push_now) begin
      lane_data <= push_data;
      lane_char <= push_char;
    end
    if (tx_accept) frame_q <= tx_data;
  end

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int HALF_PERIOD_NS = 4,
  parameter int RST_CYCLES     = 2
) (
  output logic device_clk,
  output logic rst
);

  // Free running device clock
  initial begin
    device_clk = 1'b0;
    forever #(HALF_PERIOD_NS) device_clk = ~device_clk;
  end

  // Reset is held for a fixed number of rising edges, then released
  initial begin
    rst = 1'b1;
    repeat (RST_CYCLES) @(posedge device_clk);
    rst <= 1'b0;
  end

endmodule

`default_nettype wire

//--- sim/link_props.sv
`timescale 1ns/1ps
`default_nettype none

module link_props #(
  parameter int BUF_DEPTH = 8
) (
  input wire                           device_clk,
  input wire                           rst,
  input wire                           lane_push,
  input wire                           pop,
  input wire                           head_valid,
  input wire                           credit_return,
  input wire [$clog2(BUF_DEPTH+1)-1:0] occupancy
);

  localparam int CNT_W = $clog2(BUF_DEPTH + 1);

  // Words pushed and not yet taken, counted apart from the buffer itself
  logic [CNT_W-1:0] words_held;

  always_ff @(posedge device_clk) begin
    if (rst) begin
      words_held <= '0;
    end else begin
      words_held <= words_held + CNT_W'(lane_push) - CNT_W'(pop);
    end
  end

  // ********************
  // Credit and occupancy rules
  // ********************

  // The framer holds no credit while the buffer is full
  a_no_push_full: assert property (@(posedge device_clk) disable iff (rst)
    lane_push |-> (occupancy != CNT_W'(BUF_DEPTH)))
    else $error("lane_push while the lane buffer is full");

  // Every word the deframer takes returns its credit in the next cycle
  // A pop against an empty buffer returns nothing and trips this rule
  a_credit_after_pop: assert property (@(posedge device_clk) disable iff (rst)
    pop |=> credit_return)
    else $error("credit_return missing one cycle after a pop");

  // The head is only offered while pushed words remain unread
  a_empty_head: assert property (@(posedge device_clk) disable iff (rst)
    (words_held == '0) |-> !head_valid)
    else $error("head_valid high while the lane buffer is empty");

endmodule

// The pop seen here is the deframer's request as it reaches the buffer
bind lane_buffer link_props #(
  .BUF_DEPTH (BUF_DEPTH)
) i_link_props (
  .device_clk    (device_clk),
  .rst           (rst),
  .lane_push     (lane_push),
  .pop           (pop),
  .head_valid    (head_valid),
  .credit_return (credit_return),
  .occupancy     (occupancy)
);

`default_nettype wire

//--- sim/link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module link_tb import link_pkg::*;;

  localparam int NUM_CHANNELS    = num_channels_dflt;
  localparam int FRAMES_PER_MF   = frames_per_mf_dflt;
  localparam int BUF_DEPTH       = buf_depth_dflt;
  localparam int CGS_MULTIFRAMES = cgs_multiframes_dflt;
  localparam int FRAME_W         = NUM_CHANNELS * sample_w;
  localparam int MF_WORDS        = NUM_CHANNELS * FRAMES_PER_MF;
  localparam int BRINGUP_LIMIT   = (CGS_MULTIFRAMES + 3) * MF_WORDS;
  localparam int SYSREF_PERIOD   = 4 * MF_WORDS;
  // Six bring-ups, 288 frames at half rate, the reset and stall stretches and five link drops
  localparam int RUN_LIMIT = 4 * (6 * BRINGUP_LIMIT + 288 * NUM_CHANNELS * 2 + 20 + 40 +
                                  5 * 2 * MF_WORDS);

  logic               device_clk;
  logic               rst;
  logic               sysref = 1'b0;
  logic               link_enable;
  logic               tx_valid;
  logic [FRAME_W-1:0] tx_data;
  logic               tx_ready;
  logic               rx_valid;
  logic [FRAME_W-1:0] rx_data;
  logic               rx_ready;
  logic               link_up;

  logic [FRAME_W-1:0] exp_q[$];
  logic [FRAME_W-1:0] exp_frame;
  logic               rx_valid_q;
  logic               sysref_pulse;
  logic               sysref_pulse_d;
  int                 sysref_cnt;
  int                 sysref_mode;
  int                 frame_cnt;
  int                 rx_count;
  int                 checks;
  int                 errors;
  int                 cycles;
  logic [31:0]        lcg_state;

  clk_gen i_clk_gen (.device_clk(device_clk), .rst(rst));

  link_loopback #(
    .NUM_CHANNELS    (NUM_CHANNELS),
    .FRAMES_PER_MF   (FRAMES_PER_MF),
    .BUF_DEPTH       (BUF_DEPTH),
    .CGS_MULTIFRAMES (CGS_MULTIFRAMES)
  ) i_link_loopback (
    .device_clk  (device_clk),
    .rst         (rst),
    .sysref      (sysref),
    .link_enable (link_enable),
    .tx_valid    (tx_valid),
    .tx_data     (tx_data),
    .tx_ready    (tx_ready),
    .rx_valid    (rx_valid),
    .rx_data     (rx_data),
    .rx_ready    (rx_ready),
    .link_up     (link_up)
  );

  // ********************
  // Helpers and checks
  // ********************

  function automatic logic [31:0] next_lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Channel index in the top nibble, running frame counter in the low byte
  function automatic logic [FRAME_W-1:0] frame_pattern(input int cnt);
    logic [FRAME_W-1:0] f;
    f = '0;
    for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
      f[ch*sample_w +: sample_w] = {4'(ch), 4'h0, cnt[7:0]};
    end
    return f;
  endfunction

  task automatic check_frame(input string name, input logic [FRAME_W-1:0] got,
                             input logic [FRAME_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED t=%0t %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  // ********************
  // Background processes
  // ********************

  // Periodic SYSREF, sent straight, one cycle late or inverted
  always @(posedge device_clk) begin
    if (rst) begin
      sysref_cnt     <= 0;
      sysref_pulse   <= 1'b0;
      sysref_pulse_d <= 1'b0;
      sysref         <= 1'b0;
    end else begin
      sysref_cnt     <= (sysref_cnt == SYSREF_PERIOD - 1) ? 0 : sysref_cnt + 1;
      sysref_pulse   <= (sysref_cnt == SYSREF_PERIOD - 1);
      sysref_pulse_d <= sysref_pulse;
      case (sysref_mode)
        1:       sysref <= sysref_pulse_d;
        2:       sysref <= ~sysref_pulse;
        default: sysref <= sysref_pulse;
      endcase
    end
  end

  // Accepted frames queue up and every delivered frame is matched in order
  always @(posedge device_clk) begin
    if (!rst) begin
      if (tx_valid && tx_ready) exp_q.push_back(tx_data);
      if (rx_valid && !rx_valid_q && !link_up) begin
        report_problem("rx_valid rose while link_up was low");
      end
      if (rx_valid && rx_ready) begin
        rx_count++;
        if (exp_q.size() == 0) begin
          report_problem("frame delivered with no accepted frame outstanding");
        end else begin
          exp_frame = exp_q.pop_front();
          check_frame("rx_data", rx_data, exp_frame);
        end
      end
    end
    rx_valid_q <= rx_valid;
  end

  // Watchdog over the whole run
  always @(posedge device_clk) begin
    cycles++;
    if (cycles >= RUN_LIMIT) begin
      $display("Timeout: run passed %0d cycles without finishing", RUN_LIMIT);
      $display("Errors found");
      $finish;
    end
  end

  // ********************
  // Stimulus tasks
  // ********************

  // Called right after a clock edge; moves the source on when a frame went in
  task automatic source_step(input int n, inout int sent);
    if (tx_valid && tx_ready) begin
      sent++;
      frame_cnt++;
      if (sent >= n) tx_valid <= 1'b0;
      else tx_data <= frame_pattern(frame_cnt);
    end
  endtask

  task automatic send_frames(input int n, input bit random_ready, inout int sent);
    tx_data  <= frame_pattern(frame_cnt);
    tx_valid <= (sent < n);
    while (sent < n) begin
      @(posedge device_clk);
      if (random_ready) begin
        lcg_state = next_lcg(lcg_state);
        rx_ready <= lcg_state[31];
      end
      source_step(n, sent);
    end
    rx_ready <= 1'b1;
  endtask

  task automatic wait_drain(input int n);
    int c;
    c = 0;
    while ((exp_q.size() != 0) && (c < n * NUM_CHANNELS * 4 + 2 * MF_WORDS)) begin
      @(posedge device_clk);
      c++;
    end
    if (exp_q.size() != 0) report_problem("accepted frames never arrived at the sink");
  endtask

  task automatic bring_up();
    int c;
    c = 0;
    link_enable <= 1'b1;
    do begin
      @(posedge device_clk);
      c++;
    end while (!link_up && (c < BRINGUP_LIMIT));
    check_flag("link_up", link_up, 1'b1);
  endtask

  // Drops the link and waits for the lane to empty and link_up to fall
  task automatic link_down();
    int c;
    c = 0;
    link_enable <= 1'b0;
    tx_valid    <= 1'b0;
    do begin
      @(posedge device_clk);
      c++;
    end while ((i_link_loopback.head_valid || link_up) && (c < 4 * MF_WORDS));
    check_flag("link_up", link_up, 1'b0);
    repeat (2) @(posedge device_clk);
    exp_q.delete();
  endtask

  task automatic data_test(input int n, input bit random_ready);
    int sent;
    int start;
    sent  = 0;
    start = rx_count;
    send_frames(n, random_ready, sent);
    wait_drain(n);
    if (rx_count - start != n) report_problem("delivered frame count differs from sent");
  endtask

  task automatic finish_test(input string name, input int err_start);
    $display("test %s finished, %0d new failures", name, errors - err_start);
  endtask

  // ********************
  // Directed tests
  // ********************

  task automatic test_reset_state();
    int e;
    e = errors;
    repeat (20) begin
      @(posedge device_clk);
      check_flag("tx_ready", tx_ready, 1'b0);
      check_flag("rx_valid", rx_valid, 1'b0);
      check_flag("link_up", link_up, 1'b0);
    end
    finish_test("reset_state", e);
  endtask

  task automatic test_back_pressure();
    int e;
    int sent;
    e    = errors;
    sent = 0;
    link_down();
    bring_up();
    // A long stall at the sink must empty the credits and close tx_ready
    tx_data  <= frame_pattern(frame_cnt);
    tx_valid <= 1'b1;
    rx_ready <= 1'b0;
    repeat (40) begin
      @(posedge device_clk);
      source_step(64, sent);
    end
    check_flag("tx_ready", tx_ready, 1'b0);
    send_frames(64, 1'b1, sent);
    wait_drain(64);
    finish_test("back_pressure", e);
  endtask

  task automatic test_relink();
    int e;
    int c;
    int sent;
    e    = errors;
    sent = 0;
    link_down();
    bring_up();
    send_frames(16, 1'b0, sent);
    link_enable <= 1'b0;
    c = 0;
    while (i_link_loopback.head_valid && (c < 4 * MF_WORDS)) begin
      @(posedge device_clk);
      c++;
    end
    c = 0;
    while (link_up && (c < MF_WORDS + 2)) begin
      @(posedge device_clk);
      c++;
    end
    check_flag("link_up", link_up, 1'b0);
    repeat (2) @(posedge device_clk);
    // Frames cut off by the drop are forgotten
    exp_q.delete();
    bring_up();
    data_test(16, 1'b0);
    finish_test("relink", e);
  endtask

  initial begin
    int e;
    link_enable <= 1'b0;
    tx_valid    <= 1'b0;
    tx_data     <= '0;
    rx_ready    <= 1'b1;
    sysref_mode <= 0;
    frame_cnt    = 0;
    rx_count     = 0;
    checks       = 0;
    errors       = 0;
    cycles       = 0;
    lcg_state    = 32'h2378_dd66;
    @(negedge rst);
    test_reset_state();
    e = errors;
    bring_up();
    finish_test("bring_up", e);
    e = errors;
    data_test(64, 1'b0);
    finish_test("data_integrity", e);
    test_back_pressure();
    for (int m = 1; m <= 2; m++) begin
      e = errors;
      link_down();
      sysref_mode <= m;
      bring_up();
      data_test(64, 1'b0);
      finish_test((m == 1) ? "sysref_delayed" : "sysref_inverted", e);
    end
    test_relink();
    $display("Checks: %0d, failures: %0d", checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
